// File: include/rp_params.svh
`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

////////////////////
// Drive geometry
////////////////////

// Highest valid sector within a track
`define RP_LAST_SECTOR 19

// Highest valid track (head) within a cylinder
`define RP_LAST_TRACK 18

// Highest valid cylinder
`define RP_LAST_CYL 814

////////////////////
// Function timing
////////////////////

// Busy cycles of a seek
`define RP_SEEK_CYCLES 8

// Busy cycles of one sector transfer
`define RP_XFER_CYCLES 12

`endif

// File: rtl/rpPkg.sv
package rpPkg;

   ////////////////////
   // Basic words
   ////////////////////

   // Bus data word
   typedef logic [35:0] rpData_t;

   // Drive register value
   typedef logic [15:0] rpWord_t;

   // Register select on the bus
   typedef logic [4:0] rpRegAddr_t;

   // Register numbers
   localparam rpRegAddr_t REG_CS1 = 5'o00;
   localparam rpRegAddr_t REG_ER1 = 5'o02;
   localparam rpRegAddr_t REG_DA  = 5'o05;
   localparam rpRegAddr_t REG_OF  = 5'o11;
   localparam rpRegAddr_t REG_DC  = 5'o25;

   // Disk address fields
   typedef logic [5:0] rpSector_t;
   typedef logic [5:0] rpTrack_t;
   typedef logic [9:0] rpCyl_t;

   // Function code, CS1 bits 5:1
   typedef logic [4:0] rpFunc_t;

   localparam rpFunc_t FN_NOP    = 5'o00;
   localparam rpFunc_t FN_SEEK   = 5'o02;
   localparam rpFunc_t FN_DRVCLR = 5'o04;
   localparam rpFunc_t FN_WRITE  = 5'o30;
   localparam rpFunc_t FN_READ   = 5'o34;

   ////////////////////
   // Engine and events
   ////////////////////

   // Function engine states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CLEAR,
      ST_ILLFUN,
      ST_INVADDR,
      ST_WRLOCK,
      ST_SEEK,
      ST_XFER
   } rpState_t;

   // Registered write strobes with their data
   typedef struct packed {
      logic    cs1;
      logic    da;
      logic    of;
      logic    dc;
      logic    er1;
      logic    refused;
      rpData_t data;
   } rpWrites_t;

   // One-cycle event pulses toward the error register
   typedef struct packed {
      logic clear;
      logic illFun;
      logic invAddr;
      logic wrLock;
      logic addrOverflow;
   } rpEvents_t;

endpackage

// File: rtl/rpWriteDecode.sv
`timescale 1ns/1ps

module rpWriteDecode (
   input  logic              clk,
   input  logic              rst,
   input  logic              busWrite,
   input  rpPkg::rpRegAddr_t busAddr,
   input  rpPkg::rpData_t    busData,
   input  logic              dry,
   output rpPkg::rpWrites_t  writes
);

   import rpPkg::*;

   // Raw register hits
   logic isCs1;
   logic isDa;
   logic isOf;
   logic isDc;
   logic isEr1;
   logic isDrive;

   // Strobes in struct order: cs1, da, of, dc, er1, refused
   logic [5:0] strobeQ;
   rpData_t    dataQ;

   ////////////////////
   // Address decode
   ////////////////////

   always_comb
   begin
      isCs1   = busWrite && (busAddr == REG_CS1);
      isDa    = busWrite && (busAddr == REG_DA);
      isOf    = busWrite && (busAddr == REG_OF);
      isDc    = busWrite && (busAddr == REG_DC);
      isEr1   = busWrite && (busAddr == REG_ER1);
      // Registers that refuse changes while busy
      isDrive = isCs1 || isDa || isOf || isDc;
   end

   // Strobes registered, one cycle after the bus write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         strobeQ <= '0;
      end
      else
      begin
         strobeQ[5] <= isCs1 && dry;
         strobeQ[4] <= isDa && dry;
         strobeQ[3] <= isOf && dry;
         strobeQ[2] <= isDc && dry;
         // ER1 always gets through, even when busy
         strobeQ[1] <= isEr1;
         // Busy drive turns the write into a refusal
         strobeQ[0] <= isDrive && !dry;
      end
   end

   // Data word follows the strobe it belongs to
   always_ff @(posedge clk)
   begin
      if (busWrite)
      begin
         dataQ <= busData;
      end
   end

   assign writes = {strobeQ, dataQ};

endmodule

// File: rtl/rpAddrRegs.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module rpAddrRegs (
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  rpPkg::rpWrites_t writes,
   input  logic             incSector,
   input  logic             clear,
   output rpPkg::rpWord_t   rpDa,
   output rpPkg::rpWord_t   rpDc,
   output logic             addrValid,
   output logic             addrOverflow
);

   import rpPkg::*;

   // Geometry limits in field widths
   localparam rpSector_t LastSector = rpSector_t'(`RP_LAST_SECTOR);
   localparam rpTrack_t  LastTrack  = rpTrack_t'(`RP_LAST_TRACK);
   localparam rpCyl_t    LastCyl    = rpCyl_t'(`RP_LAST_CYL);

   rpSector_t sector;
   rpTrack_t  track;
   rpCyl_t    cyl;

   // End-of-field flags for the carry chain
   logic atLastSector;
   logic atLastTrack;
   logic atLastCyl;

   always_comb
   begin
      atLastSector = (sector == LastSector);
      atLastTrack  = (track == LastTrack);
      atLastCyl    = (cyl == LastCyl);
   end

   ////////////////////
   // Address fields
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         sector <= '0;
         track  <= '0;
         cyl    <= '0;
      end
      else if (clr || clear)
      begin
         sector <= '0;
         track  <= '0;
         cyl    <= '0;
      end
      else if (writes.da || writes.dc)
      begin
         // DA: track in 13:8, sector in 5:0
         if (writes.da)
         begin
            sector <= writes.data[5:0];
            track  <= writes.data[13:8];
         end
         // DC: cylinder in 9:0
         if (writes.dc)
         begin
            cyl <= writes.data[9:0];
         end
      end
      else if (incSector)
      begin
         if (!atLastSector)
         begin
            sector <= sector + 1'b1;
         end
         else
         begin
            // Sector wraps, carry into track
            sector <= '0;
            if (!atLastTrack)
            begin
               track <= track + 1'b1;
            end
            else
            begin
               // Track wraps, carry into cylinder
               track <= '0;
               cyl   <= atLastCyl ? '0 : cyl + 1'b1;
            end
         end
      end
   end

   // Stepping off the final sector of the disk
   assign addrOverflow = incSector && atLastSector && atLastTrack && atLastCyl;

   // Every field inside the geometry
   assign addrValid = (sector <= LastSector) && (track <= LastTrack) && (cyl <= LastCyl);

   // Register images
   assign rpDa = {2'b00, track, 2'b00, sector};
   assign rpDc = {6'b000000, cyl};

endmodule

// File: rtl/rpDriveCtrl.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module rpDriveCtrl (
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  rpPkg::rpWrites_t writes,
   input  logic             addrValid,
   input  logic             writeLock,
   output rpPkg::rpEvents_t events,
   output logic             incSector,
   output logic             dry
);

   import rpPkg::*;

   // Counter sized for the longer of the two busy times
   localparam int MaxCycles = (`RP_XFER_CYCLES > `RP_SEEK_CYCLES) ?
                              `RP_XFER_CYCLES : `RP_SEEK_CYCLES;
   localparam int CntWidth  = $clog2(MaxCycles + 1);

   // Counter loads, last busy cycle at zero
   localparam logic [CntWidth-1:0] SeekLoad = CntWidth'(`RP_SEEK_CYCLES - 1);
   localparam logic [CntWidth-1:0] XferLoad = CntWidth'(`RP_XFER_CYCLES - 1);

   rpState_t            state;
   rpState_t            startState;
   logic [CntWidth-1:0] busyCnt;

   // Function request from a CS1 write
   logic    cs1Go;
   rpFunc_t func;

   ////////////////////
   // Function decode
   ////////////////////

   always_comb
   begin
      // GO is CS1 bit 0
      cs1Go = writes.cs1 && writes.data[0];
      func  = writes.data[5:1];

      case (func)
         FN_NOP:
         begin
            startState = ST_IDLE;
         end
         FN_DRVCLR:
         begin
            startState = ST_CLEAR;
         end
         FN_SEEK, FN_READ, FN_WRITE:
         begin
            // Address check comes before write lock
            if (!addrValid)
               startState = ST_INVADDR;
            else if ((func == FN_WRITE) && writeLock)
               startState = ST_WRLOCK;
            else if (func == FN_SEEK)
               startState = ST_SEEK;
            else
               startState = ST_XFER;
         end
         default:
         begin
            startState = ST_ILLFUN;
         end
      endcase
   end

   ////////////////////
   // State machine
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= ST_IDLE;
         busyCnt <= '0;
      end
      else if (clr)
      begin
         // Controller clear aborts any function
         state   <= ST_IDLE;
         busyCnt <= '0;
      end
      else
      begin
         case (state)
            ST_SEEK, ST_XFER:
            begin
               if (busyCnt == '0)
                  state <= ST_IDLE;
               else
                  busyCnt <= busyCnt - 1'b1;
            end
            default:
            begin
               // Idle and one-cycle states accept a new function
               if (cs1Go)
               begin
                  state   <= startState;
                  busyCnt <= (startState == ST_SEEK) ? SeekLoad : XferLoad;
               end
               else
               begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // Event pulses, one per one-cycle state
   always_comb
   begin
      events         = '0;
      events.clear   = (state == ST_CLEAR);
      events.illFun  = (state == ST_ILLFUN);
      events.invAddr = (state == ST_INVADDR);
      events.wrLock  = (state == ST_WRLOCK);
      // Overflow belongs to the address counter
      events.addrOverflow = 1'b0;
   end

   // Sector advances on the last transfer cycle
   assign incSector = (state == ST_XFER) && (busyCnt == '0);

   // Ready unless a counted function is running
   assign dry = (state != ST_SEEK) && (state != ST_XFER);

endmodule

// File: rtl/rpErr1.sv
`timescale 1ns/1ps

module rpErr1 (
   input  logic             clk,
   input  logic             rst,
   input  logic             clr,
   input  rpPkg::rpWrites_t writes,
   input  rpPkg::rpEvents_t events,
   input  logic             addrOverflow,
   output rpPkg::rpWord_t   rpEr1
);

   import rpPkg::*;

   ////////////////////
   // Flag positions
   ////////////////////

   // 15 DCK, 14 UNS, 13 IOP, 12 DTE
   // 11 WLE, 10 IAE,  9 AOE,  8 HCRC
   //  7 HCE,  6 ECH,  5 WCF,  4 FER
   //  3 PAR,  2 RMR,  1 ILR,  0 ILF

   // Flags with a hardware source
   localparam int BitWle = 11;
   localparam int BitIae = 10;
   localparam int BitAoe = 9;
   localparam int BitRmr = 2;
   localparam int BitIlf = 0;

   rpWord_t hwSet;
   rpWord_t flags;
   logic    flagClear;

   // Drive clear function or controller clear
   assign flagClear = clr || events.clear;

   // Hardware set mask
   always_comb
   begin
      hwSet         = '0;
      hwSet[BitWle] = events.wrLock;
      hwSet[BitIae] = events.invAddr;
      // Overflow from the address counter
      hwSet[BitAoe] = addrOverflow;
      // Refused write while busy
      hwSet[BitRmr] = writes.refused;
      hwSet[BitIlf] = events.illFun;
   end

   ////////////////////
   // Error flags
   ////////////////////

   // Per flag: clear, then register write, then hardware set
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         flags <= '0;
      end
      else if (flagClear)
      begin
         flags <= '0;
      end
      else if (writes.er1)
      begin
         // Whole word loaded from data bits 15:0
         flags <= writes.data[15:0];
      end
      else
      begin
         // Hardware sets are sticky
         flags <= flags | hwSet;
      end
   end

   assign rpEr1 = flags;

endmodule

// File: rtl/rpDrive.sv
`timescale 1ns/1ps

module rpDrive (
   input  logic              clk,
   input  logic              rst,
   input  logic              clr,
   input  logic              busWrite,
   input  rpPkg::rpRegAddr_t busAddr,
   input  rpPkg::rpData_t    busData,
   input  logic              writeLock,
   output rpPkg::rpWord_t    rpEr1,
   output rpPkg::rpWord_t    rpDa,
   output rpPkg::rpWord_t    rpDc,
   output rpPkg::rpWord_t    rpDs
);

   import rpPkg::*;

   // Stage 1 to stage 2 and 3
   rpWrites_t writes;

   // Stage 2 internals
   rpEvents_t events;
   logic      dry;
   logic      incSector;
   logic      addrValid;
   logic      addrOverflow;

   ////////////////////
   // Stage 1
   ////////////////////

   rpWriteDecode i_writeDecode (
      .clk      (clk),
      .rst      (rst),
      .busWrite (busWrite),
      .busAddr  (busAddr),
      .busData  (busData),
      .dry      (dry),
      .writes   (writes)
   );

   ////////////////////
   // Stage 2
   ////////////////////

   rpAddrRegs i_addrRegs (
      .clk          (clk),
      .rst          (rst),
      .clr          (clr),
      .writes       (writes),
      .incSector    (incSector),
      .clear        (events.clear),
      .rpDa         (rpDa),
      .rpDc         (rpDc),
      .addrValid    (addrValid),
      .addrOverflow (addrOverflow)
   );

   rpDriveCtrl i_driveCtrl (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .writes    (writes),
      .addrValid (addrValid),
      .writeLock (writeLock),
      .events    (events),
      .incSector (incSector),
      .dry       (dry)
   );

   ////////////////////
   // Stage 3
   ////////////////////

   rpErr1 i_err1 (
      .clk          (clk),
      .rst          (rst),
      .clr          (clr),
      .writes       (writes),
      .events       (events),
      .addrOverflow (addrOverflow),
      .rpEr1        (rpEr1)
   );

   // Status word
   always_comb
   begin
      rpDs     = '0;
      // ERR when any ER1 flag is up
      rpDs[14] = |rpEr1;
      // Write lock switch
      rpDs[11] = writeLock;
      // Drive ready
      rpDs[7]  = dry;
   end

endmodule

// File: test/tbRpDrive.sv
`timescale 1ns/1ps

`include "rp_params.svh"

module tbRpDrive;

   import rpPkg::*;

   ////////////////////
   // Test constants
   ////////////////////

   localparam int NumTests    = 33;
   localparam int ResetCycles = 4;
   // Worst entry is one transfer plus write and settle cycles
   localparam int CycleLimit  = NumTests * (`RP_XFER_CYCLES + 8) + 50;

   // ER1 flag masks
   localparam rpWord_t FlagIlf = 16'h0001;
   localparam rpWord_t FlagRmr = 16'h0004;
   localparam rpWord_t FlagAoe = 16'h0200;
   localparam rpWord_t FlagIae = 16'h0400;
   localparam rpWord_t FlagWle = 16'h0800;

   // Status word bits
   localparam int DsDry = 7;
   localparam int DsWrl = 11;
   localparam int DsErr = 14;

   // CS1 words with GO set
   localparam rpData_t Cs1DrvClr  = {30'b0, FN_DRVCLR, 1'b1};
   localparam rpData_t Cs1Seek    = {30'b0, FN_SEEK, 1'b1};
   localparam rpData_t Cs1Read    = {30'b0, FN_READ, 1'b1};
   localparam rpData_t Cs1Write   = {30'b0, FN_WRITE, 1'b1};
   localparam rpData_t Cs1Illegal = {30'b0, 5'o06, 1'b1};

   // One bus write and what the drive should show afterwards
   typedef struct {
      string      name;
      rpRegAddr_t addr;
      rpData_t    data;
      logic       writeLock;
      logic       waitDone;
      rpWord_t    expEr1;
      rpWord_t    expDa;
      rpWord_t    expDc;
   } testEntry_t;

   testEntry_t tests [NumTests];
   int         numEntries;

   logic       clk;
   logic       rst;
   logic       clr;
   logic       busWrite;
   rpRegAddr_t busAddr;
   rpData_t    busData;
   logic       writeLock;
   rpWord_t    rpEr1;
   rpWord_t    rpDa;
   rpWord_t    rpDc;
   rpWord_t    rpDs;

   int seed;
   int errorCount;
   int checkCount;
   int cycleCount;

   rpDrive i_dut (
      .clk       (clk),
      .rst       (rst),
      .clr       (clr),
      .busWrite  (busWrite),
      .busAddr   (busAddr),
      .busData   (busData),
      .writeLock (writeLock),
      .rpEr1     (rpEr1),
      .rpDa      (rpDa),
      .rpDc      (rpDc),
      .rpDs      (rpDs)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // DA layout, track in 13:8 and sector in 5:0
   function automatic rpWord_t daWord(input int track, input int sector);
      return rpWord_t'((track << 8) | sector);
   endfunction

   // Inputs change 2 ns after the edge
   task automatic nextCycle();
      @(posedge clk);
      #2;
   endtask

   task automatic addTest(input string name, input rpRegAddr_t addr, input rpData_t data,
                          input logic wl, input logic waitDone, input rpWord_t expEr1,
                          input rpWord_t expDa, input rpWord_t expDc);
      tests[numEntries].name      = name;
      tests[numEntries].addr      = addr;
      tests[numEntries].data      = data;
      tests[numEntries].writeLock = wl;
      tests[numEntries].waitDone  = waitDone;
      tests[numEntries].expEr1    = expEr1;
      tests[numEntries].expDa     = expDa;
      tests[numEntries].expDc     = expDc;
      numEntries++;
   endtask

   task automatic checkWord(input string name, input string what, input rpWord_t exp,
                            input rpWord_t act);
      checkCount++;
      if (act !== exp)
      begin
         $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
         errorCount++;
      end
   endtask

   task automatic checkBit(input string name, input string what, input logic exp,
                           input logic act);
      checkCount++;
      if (act !== exp)
      begin
         $display("Fail %s %s: expected %b, actual %b", name, what, exp, act);
         errorCount++;
      end
   endtask

   // One-cycle write strobe on the bus
   task automatic applyWrite(input int idx);
      busAddr   = tests[idx].addr;
      busData   = tests[idx].data;
      writeLock = tests[idx].writeLock;
      busWrite  = 1'b1;
      nextCycle();
      busWrite  = 1'b0;
   endtask

   // Engine has moved one edge later, then run until DRY and settle
   task automatic waitReady();
      nextCycle();
      while (!rpDs[DsDry])
         nextCycle();
      repeat (3) nextCycle();
   endtask

   task automatic checkEntry(input int idx);
      checkWord(tests[idx].name, "ER1", tests[idx].expEr1, rpEr1);
      checkWord(tests[idx].name, "DA", tests[idx].expDa, rpDa);
      checkWord(tests[idx].name, "DC", tests[idx].expDc, rpDc);
      // ERR is the OR of all ER1 flags
      checkBit(tests[idx].name, "ERR", |tests[idx].expEr1, rpDs[DsErr]);
      checkBit(tests[idx].name, "DRY", 1'b1, rpDs[DsDry]);
      checkBit(tests[idx].name, "WRL", tests[idx].writeLock, rpDs[DsWrl]);
   endtask

   ////////////////////
   // Stimulus table
   ////////////////////

   task automatic buildTable();
      rpData_t r;
      rpWord_t er1Now;
      seed   = 94;
      er1Now = '0;
      // Random ER1 patterns read back as written
      for (int i = 0; i < 4; i++)
      begin
         r = rpData_t'({$random(seed), $random(seed)});
         er1Now = r[15:0];
         addTest($sformatf("er1Random%0d", i), REG_ER1, r, 1'b0, 1'b1, er1Now, '0, '0);
      end
      addTest("daLoad", REG_DA, rpData_t'(daWord(5, 7)), 1'b0, 1'b1, er1Now, daWord(5, 7), '0);
      // OF accepted but not stored
      addTest("ofIgnored", REG_OF, 36'h1234, 1'b0, 1'b1, er1Now, daWord(5, 7), '0);
      addTest("dcLoad", REG_DC, 36'd100, 1'b0, 1'b1, er1Now, daWord(5, 7), 16'd100);
      addTest("drvClear", REG_CS1, Cs1DrvClr, 1'b0, 1'b1, '0, '0, '0);

      // Illegal function and write lock
      addTest("illFunc", REG_CS1, Cs1Illegal, 1'b0, 1'b1, FlagIlf, '0, '0);
      addTest("clearIlf", REG_CS1, Cs1DrvClr, 1'b0, 1'b1, '0, '0, '0);
      addTest("daSet", REG_DA, rpData_t'(daWord(3, 4)), 1'b0, 1'b1, '0, daWord(3, 4), '0);
      addTest("dcSet", REG_DC, 36'd200, 1'b0, 1'b1, '0, daWord(3, 4), 16'd200);
      addTest("wrLocked", REG_CS1, Cs1Write, 1'b1, 1'b1, FlagWle, daWord(3, 4), 16'd200);
      addTest("clearWle", REG_CS1, Cs1DrvClr, 1'b0, 1'b1, '0, '0, '0);

      // Seek outside and inside the geometry
      addTest("daBad", REG_DA, rpData_t'(daWord(30, 40)), 1'b0, 1'b1, '0, daWord(30, 40), '0);
      addTest("seekBad", REG_CS1, Cs1Seek, 1'b0, 1'b1, FlagIae, daWord(30, 40), '0);
      addTest("clearIae", REG_CS1, Cs1DrvClr, 1'b0, 1'b1, '0, '0, '0);
      addTest("daGood", REG_DA, rpData_t'(daWord(10, 2)), 1'b0, 1'b1, '0, daWord(10, 2), '0);
      addTest("dcGood", REG_DC, 36'd400, 1'b0, 1'b1, '0, daWord(10, 2), 16'd400);
      addTest("seekGood", REG_CS1, Cs1Seek, 1'b0, 1'b1, '0, daWord(10, 2), 16'd400);

      // Sector increment and carries
      addTest("readMid", REG_CS1, Cs1Read, 1'b0, 1'b1, '0, daWord(10, 3), 16'd400);
      addTest("daLastSec", REG_DA, rpData_t'(daWord(10, 19)), 1'b0, 1'b1, '0,
              daWord(10, 19), 16'd400);
      addTest("readTrkCarry", REG_CS1, Cs1Read, 1'b0, 1'b1, '0, daWord(11, 0), 16'd400);
      addTest("daLastTrk", REG_DA, rpData_t'(daWord(18, 19)), 1'b0, 1'b1, '0,
              daWord(18, 19), 16'd400);
      addTest("readCylCarry", REG_CS1, Cs1Read, 1'b0, 1'b1, '0, '0, 16'd401);

      // End of disk wraps and flags AOE
      addTest("daEnd", REG_DA, rpData_t'(daWord(18, 19)), 1'b0, 1'b1, '0,
              daWord(18, 19), 16'd401);
      addTest("dcEnd", REG_DC, 36'd814, 1'b0, 1'b1, '0, daWord(18, 19), 16'd814);
      addTest("readWrap", REG_CS1, Cs1Read, 1'b0, 1'b1, FlagAoe, '0, '0);

      // Write refused while a seek runs
      addTest("clearAoe", REG_CS1, Cs1DrvClr, 1'b0, 1'b1, '0, '0, '0);
      addTest("daStart", REG_DA, rpData_t'(daWord(2, 3)), 1'b0, 1'b1, '0, daWord(2, 3), '0);
      addTest("seekBusy", REG_CS1, Cs1Seek, 1'b0, 1'b0, '0, daWord(2, 3), '0);
      addTest("daRefused", REG_DA, rpData_t'(daWord(7, 7)), 1'b0, 1'b1, FlagRmr,
              daWord(2, 3), '0);
      addTest("drvClearEnd", REG_CS1, Cs1DrvClr, 1'b0, 1'b1, '0, '0, '0);

      if (numEntries != NumTests)
      begin
         $display("Stimulus table holds %0d entries instead of %0d", numEntries, NumTests);
         errorCount++;
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      rst        = 1'b1;
      clr        = 1'b0;
      busWrite   = 1'b0;
      busAddr    = '0;
      busData    = '0;
      writeLock  = 1'b0;
      errorCount = 0;
      checkCount = 0;
      numEntries = 0;
      buildTable();

      repeat (ResetCycles) @(posedge clk);
      #2;
      rst = 1'b0;
      nextCycle();

      // Reset state
      checkWord("reset", "ER1", '0, rpEr1);
      checkWord("reset", "DA", '0, rpDa);
      checkWord("reset", "DC", '0, rpDc);
      checkBit("reset", "DRY", 1'b1, rpDs[DsDry]);
      checkBit("reset", "ERR", 1'b0, rpDs[DsErr]);

      for (int idx = 0; idx < numEntries; idx++)
      begin
         applyWrite(idx);
         if (tests[idx].waitDone)
         begin
            waitReady();
            checkEntry(idx);
         end
         else
         begin
            // Next write lands while the function is busy
            nextCycle();
            checkBit(tests[idx].name, "DRY", 1'b0, rpDs[DsDry]);
         end
      end

      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("Done: no errors");
      end
      else
      begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog on total cycles
   initial
   begin
      cycleCount = 0;
      while (cycleCount < CycleLimit)
      begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Simulation timed out after %0d cycles, DRY never came back", cycleCount);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+include
rtl/rpPkg.sv
rtl/rpWriteDecode.sv
rtl/rpAddrRegs.sv
rtl/rpDriveCtrl.sv
rtl/rpErr1.sv
rtl/rpDrive.sv
test/tbRpDrive.sv

// File: run.sh
#!/bin/sh
# Compile and run the rpDrive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
   --top-module tbRpDrive --Mdir "$OBJ" -o simRpDrive
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/simRpDrive" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Fail message in the log decides the result
if grep -q "Done: errors found" "$LOG"; then
   exit 1
fi
exit 0
